// File: verilog.f
+incdir+source
source/rv_isa_pkg.sv
source/ds_ctrl_pkg.sv
source/gpr_read_if.sv
source/ds_stage_ctrl.sv
source/ds_decoder.sv
source/ds_gpr_file.sv
source/ds_operand_fwd.sv
source/ds_branch_unit.sv
source/ds_stage_top.sv
tb/tb_ds_stage.sv

// File: run_sim.sh
#!/bin/sh
# build and run the decode stage testbench with Verilator, then judge the log
verilator --binary --timing --assert --top-module tb_ds_stage -f verilog.f -o tb_ds_stage \
  > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/tb_ds_stage > sim.log 2>&1 || echo "simulator returned an error status"
cat sim.log
grep -qx "PASS: all tests" sim.log && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

// File: tb/tb_ds_stage.sv
// fetch, execute and write-back are modelled here; operand checks rely on the register fill running first
`include "ds_params.svh"

module tb_ds_stage;

  localparam int timeout_cycles = 50;
  // lui, auipc, jal, jalr, system, op-imm-32, op-32, misc-mem
  localparam logic [6:0] bad_ops [8] = '{7'h37, 7'h17, 7'h6f, 7'h67, 7'h73, 7'h1b, 7'h3b, 7'h0f};

  logic                       i_clk;
  logic                       i_rst;
  logic                       i_es_allowin;
  logic                       i_fs_to_ds_valid;
  logic [`DS_INST_WD-1:0]     i_fs_inst;
  logic [`DS_XLEN-1:0]        i_fs_pc;
  logic                       i_ws_gpr_wen;
  logic [`DS_GPR_ADDR_WD-1:0] i_ws_gpr_waddr;
  logic [`DS_XLEN-1:0]        i_ws_gpr_wdata;
  logic [`DS_GPR_ADDR_WD-1:0] i_es_byp_rd;
  logic [`DS_XLEN-1:0]        i_es_byp_data;
  logic                       i_es_load_sel;
  logic [`DS_GPR_ADDR_WD-1:0] i_ms_byp_rd;
  logic [`DS_XLEN-1:0]        i_ms_byp_data;
  logic [`DS_GPR_ADDR_WD-1:0] i_ws_byp_rd;
  logic [`DS_XLEN-1:0]        i_ws_byp_data;
  logic                       o_ds_allowin;
  logic                       o_ds_to_es_valid;
  logic                       o_br_taken;
  logic [`DS_XLEN-1:0]        o_br_target;
  logic [`DS_XLEN-1:0]        o_es_pc;
  logic [`DS_XLEN-1:0]        o_es_rs1_data;
  logic [`DS_XLEN-1:0]        o_es_rs2_data;
  logic [`DS_XLEN-1:0]        o_es_imm;
  logic [`DS_GPR_ADDR_WD-1:0] o_es_rd;
  logic                       o_es_alu_op;
  logic                       o_es_src2_imm_sel;
  logic                       o_es_gpr_wen;
  logic                       o_es_mem_ren;
  logic                       o_es_mem_wen;
  logic                       o_es_load_sel;
  logic                       o_es_invalid;

  logic [6:0]          es_ctrl; // alu, imm sel, wen, ren, mem wen, load, invalid
  logic [`DS_XLEN-1:0] ref_regs [`DS_GPR_NUM];
  logic [31:0]         rng;
  int                  errors;
  int                  checks;

  ds_stage_top u_ds_stage_top (.*);

  assign es_ctrl = {o_es_alu_op, o_es_src2_imm_sel, o_es_gpr_wen, o_es_mem_ren,
                    o_es_mem_wen, o_es_load_sel, o_es_invalid};

  initial begin
    i_clk = 1'b0;
    forever #20 i_clk = ~i_clk;
  end

  // execute refuses a valid instruction, so decode must freeze it
  assert property (@(posedge i_clk) disable iff (i_rst)
      (o_ds_to_es_valid && !i_es_allowin) |-> !o_ds_allowin)
    else begin
      errors++;
      $display("Mismatch at %0t: o_ds_allowin got 1 expected 0", $time);
    end

  assert property (@(posedge i_clk) disable iff (i_rst)
      (o_ds_to_es_valid && !i_es_allowin) |=> (o_ds_to_es_valid && $stable(o_es_pc) &&
      $stable(o_es_imm) && $stable(o_es_rd) && $stable(es_ctrl)))
    else begin
      errors++;
      $display("execute outputs changed at %0t under back-pressure", $time);
    end

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // first nonzero match wins, es before ms before ws
  function automatic logic [63:0] fwd_model(input logic [4:0] rs);
    if (i_es_byp_rd != '0 && i_es_byp_rd == rs) return i_es_byp_data;
    if (i_ms_byp_rd != '0 && i_ms_byp_rd == rs) return i_ms_byp_data;
    if (i_ws_byp_rd != '0 && i_ws_byp_rd == rs) return i_ws_byp_data;
    return ref_regs[rs];
  endfunction

  function automatic logic [4:0] pick_rd(input logic [1:0] sel, input logic [4:0] a,
                                         input logic [4:0] b, input logic [4:0] other);
    case (sel)
      2'd0:    return '0;
      2'd1:    return a;
      2'd2:    return b;
      default: return other;
    endcase
  endfunction

  task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic report_timeout(input string what);
    errors++;
    $display("timeout at %0t: %s", $time, what);
  endtask

  task automatic write_gpr(input logic [4:0] addr, input logic [63:0] data);
    @(posedge i_clk);
    #1;
    i_ws_gpr_wen   = 1'b1;
    i_ws_gpr_waddr = addr;
    i_ws_gpr_wdata = data;
    @(posedge i_clk);
    #1;
    i_ws_gpr_wen = 1'b0;
    if (addr != '0) ref_regs[addr] = data; // x0 writes dropped
  endtask

  // hold fetch valid until the stage takes it; returns 2 units after the latch edge
  task automatic present(input logic [31:0] inst, input logic [63:0] pc);
    int n;
    n = 0;
    @(posedge i_clk);
    #1;
    i_fs_to_ds_valid = 1'b1;
    i_fs_inst        = inst;
    i_fs_pc          = pc;
    #1;
    while (!o_ds_allowin && n < timeout_cycles) begin
      @(posedge i_clk);
      #2;
      n++;
    end
    if (!o_ds_allowin) report_timeout("fetch waited but allowin never rose");
    @(posedge i_clk);
    #1;
    i_fs_to_ds_valid = 1'b0;
    #1;
  endtask

  initial begin : main
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [11:0] imm12;
    logic [12:0] imm13;
    logic [63:0] simm;
    logic [63:0] pc;
    logic [63:0] target;
    logic [31:0] inst;
    logic [31:0] r2;
    logic [6:0]  exp_ctrl;
    logic [4:0]  exp_rd;
    logic [63:0] exp_imm;
    logic [63:0] exp_rs2;
    logic        bne;
    logic        exp_taken;
    int          n;
    errors           = 0;
    checks           = 0;
    rng              = 32'ha406ef67;
    i_rst            = 1'b1;
    i_es_allowin     = 1'b1;
    i_fs_to_ds_valid = 1'b0;
    i_fs_inst        = '0;
    i_fs_pc          = '0;
    i_ws_gpr_wen     = 1'b0;
    i_ws_gpr_waddr   = '0;
    i_ws_gpr_wdata   = '0;
    i_es_byp_rd      = '0;
    i_es_byp_data    = '0;
    i_es_load_sel    = 1'b0;
    i_ms_byp_rd      = '0;
    i_ms_byp_data    = '0;
    i_ws_byp_rd      = '0;
    i_ws_byp_data    = '0;
    for (int r = 0; r < `DS_GPR_NUM; r++) ref_regs[r] = '0;
    repeat (4) @(posedge i_clk);
    #1;
    i_rst = 1'b0;
    #1;
    check_value("o_ds_to_es_valid", 64'(o_ds_to_es_valid), 64'd0);
    check_value("o_br_taken", 64'(o_br_taken), 64'd0);
    check_value("o_ds_allowin", 64'(o_ds_allowin), 64'd1);

    // fill every register, x0 included
    for (int r = 0; r < `DS_GPR_NUM; r++) begin
      rng = xorshift(rng);
      r2  = rng;
      rng = xorshift(rng);
      write_gpr(5'(r), {r2, rng});
    end

    // decode of each supported kind plus unsupported opcodes
    for (int k = 0; k < 30; k++) begin
      rng     = xorshift(rng);
      rd      = rng[4:0];
      rs1     = rng[9:5];
      rs2     = rng[14:10];
      imm12   = rng[26:15];
      simm    = {{52{imm12[11]}}, imm12};
      exp_rd  = rd;
      exp_imm = simm;
      exp_rs2 = '0;
      case (k % 6)
        0: begin
          inst     = {imm12, rs1, 3'b000, rd, 7'b0010011};
          exp_ctrl = 7'b0110000;
        end
        1: begin
          inst     = {7'b0000000, rs2, rs1, 3'b000, rd, 7'b0110011};
          exp_ctrl = 7'b0010000;
          exp_imm  = '0;
          exp_rs2  = ref_regs[rs2];
        end
        2: begin
          inst     = {7'b0100000, rs2, rs1, 3'b000, rd, 7'b0110011};
          exp_ctrl = 7'b1010000;
          exp_imm  = '0;
          exp_rs2  = ref_regs[rs2];
        end
        3: begin
          inst     = {imm12, rs1, 3'b011, rd, 7'b0000011};
          exp_ctrl = 7'b0111010;
        end
        4: begin
          inst     = {imm12[11:5], rs2, rs1, 3'b011, imm12[4:0], 7'b0100011};
          exp_ctrl = 7'b0100100;
          exp_rd   = '0;
          exp_rs2  = ref_regs[rs2];
        end
        default: begin
          inst     = {rng[31:7], bad_ops[rng[2:0]]};
          exp_ctrl = 7'b0000001;
        end
      endcase
      r2  = xorshift(rng);
      rng = xorshift(r2);
      pc  = {r2, rng[31:2], 2'b00};
      present(inst, pc);
      if (k % 6 == 5) begin
        check_value("o_es_invalid", 64'(o_es_invalid), 64'd1);
      end else begin
        check_value("o_es_rd", 64'(o_es_rd), 64'(exp_rd));
        check_value("o_es_imm", o_es_imm, exp_imm);
        check_value("es_ctrl", 64'(es_ctrl), 64'(exp_ctrl));
        check_value("o_es_pc", o_es_pc, pc);
        check_value("o_es_rs1_data", o_es_rs1_data, ref_regs[rs1]);
        check_value("o_es_rs2_data", o_es_rs2_data, exp_rs2);
        check_value("o_ds_to_es_valid", 64'(o_ds_to_es_valid), 64'd1);
      end
    end

    // forwarding while execute holds the add back
    for (int j = 0; j < 3; j++) begin
      rng = xorshift(rng);
      rs1 = (j == 0) ? 5'd0 : rng[4:0];
      rs2 = rng[9:5];
      rd  = rng[14:10];
      present({7'b0000000, rs2, rs1, 3'b000, rd, 7'b0110011}, 64'h1000 + 64'(j * 4));
      i_es_allowin     = 1'b0;
      i_fs_to_ds_valid = 1'b1; // next fetch waits behind the held add
      i_fs_inst        = {12'h7ff, rs1, 3'b000, rd ^ 5'd1, 7'b0010011};
      i_fs_pc          = 64'h1800 + 64'(j * 4);
      for (int s = 0; s < 12; s++) begin
        @(posedge i_clk);
        #1;
        rng           = xorshift(rng);
        r2            = xorshift(rng);
        i_es_byp_rd   = pick_rd(rng[1:0], rs1, rs2, rng[6:2]);
        i_ms_byp_rd   = pick_rd(rng[8:7], rs1, rs2, rng[13:9]);
        i_ws_byp_rd   = pick_rd(rng[15:14], rs1, rs2, rng[20:16]);
        i_es_byp_data = {r2, ~r2};
        i_ms_byp_data = {~r2, r2};
        i_ws_byp_data = {r2 ^ 32'h5a5a_5a5a, r2};
        #1;
        check_value("o_es_rs1_data", o_es_rs1_data, fwd_model(rs1));
        check_value("o_es_rs2_data", o_es_rs2_data, fwd_model(rs2));
        check_value("o_ds_allowin", 64'(o_ds_allowin), 64'd0);
      end
      @(posedge i_clk);
      #1;
      i_es_allowin     = 1'b1;
      i_fs_to_ds_valid = 1'b0;
      i_es_byp_rd      = '0;
      i_ms_byp_rd      = '0;
      i_ws_byp_rd      = '0;
    end

    // load-use stall on rs1, then on rs2
    for (int j = 0; j < 2; j++) begin
      rng = xorshift(rng);
      rd  = rng[4:0] | 5'd1;
      rs1 = (j == 0) ? rd : rd ^ 5'd1;
      rs2 = (j == 0) ? rd ^ 5'd1 : rd;
      @(posedge i_clk);
      #1;
      i_es_load_sel = 1'b1;
      i_es_byp_rd   = rd;
      i_es_byp_data = {rng, rng};
      present({7'b0000000, rs2, rs1, 3'b000, rng[9:5], 7'b0110011}, 64'h2000);
      for (int s = 0; s < 3; s++) begin
        check_value("o_ds_to_es_valid", 64'(o_ds_to_es_valid), 64'd0);
        check_value("o_ds_allowin", 64'(o_ds_allowin), 64'd0);
        @(posedge i_clk);
        #2;
      end
      i_es_load_sel = 1'b0; // load moved on to mem
      i_es_byp_rd   = '0;
      i_ms_byp_rd   = rd;
      i_ms_byp_data = {~rng, rng};
      n = 0;
      #1;
      while (!o_ds_to_es_valid && n < timeout_cycles) begin
        @(posedge i_clk);
        #2;
        n++;
      end
      if (!o_ds_to_es_valid) begin
        report_timeout("load-use stall did not end after the load left execute");
      end else begin
        check_value("o_es_rs1_data", o_es_rs1_data, fwd_model(rs1));
        check_value("o_es_rs2_data", o_es_rs2_data, fwd_model(rs2));
      end
      @(posedge i_clk);
      #1;
      i_ms_byp_rd = '0;
    end

    // beq/bne with the next fetch squashed when taken
    for (int k = 0; k < 16; k++) begin
      rng   = xorshift(rng);
      rs1   = rng[4:0];
      rs2   = rng[16] ? rng[4:0] : rng[9:5];
      bne   = rng[17];
      imm13 = {rng[21:10], 1'b0};
      rd    = rng[28:24];
      r2    = xorshift(rng);
      rng   = xorshift(r2);
      pc    = {r2, rng[31:2], 2'b00};
      target = pc + {{51{imm13[12]}}, imm13};
      inst  = {imm13[12], imm13[10:5], rs2, rs1, 2'b00, bne, imm13[4:1], imm13[11],
               7'b1100011};
      present(inst, pc);
      i_fs_to_ds_valid = 1'b1;
      i_fs_inst        = {12'd1, 5'd0, 3'b000, rd, 7'b0010011}; // addi rd, x0, 1
      i_fs_pc          = r2[5] ? target : pc + 64'd4;
      #1;
      exp_taken = (bne ? (ref_regs[rs1] != ref_regs[rs2]) : (ref_regs[rs1] == ref_regs[rs2]))
                  && (target != i_fs_pc);
      check_value("o_br_taken", 64'(o_br_taken), 64'(exp_taken));
      check_value("o_br_target", o_br_target, target);
      @(posedge i_clk);
      #1;
      i_fs_to_ds_valid = 1'b0;
      #1;
      check_value("o_es_rd", 64'(o_es_rd), exp_taken ? 64'd0 : 64'(rd));
      check_value("o_es_imm", o_es_imm, exp_taken ? 64'd0 : 64'd1);
      check_value("es_ctrl", 64'(es_ctrl), 64'(7'b0110000));
    end

    @(posedge i_clk);
    #1;
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

// File: source/ds_stage_top.sv
// execute outputs are meaningful only while o_ds_to_es_valid is high; register file needs write-back init
`include "ds_params.svh"

module ds_stage_top (
  input  logic                       i_clk,
  input  logic                       i_rst,
  input  logic                       i_es_allowin,
  input  logic                       i_fs_to_ds_valid,
  input  logic [`DS_INST_WD-1:0]     i_fs_inst,
  input  logic [`DS_XLEN-1:0]        i_fs_pc,
  // write back
  input  logic                       i_ws_gpr_wen,
  input  logic [`DS_GPR_ADDR_WD-1:0] i_ws_gpr_waddr,
  input  logic [`DS_XLEN-1:0]        i_ws_gpr_wdata,
  // bypass
  input  logic [`DS_GPR_ADDR_WD-1:0] i_es_byp_rd,
  input  logic [`DS_XLEN-1:0]        i_es_byp_data,
  input  logic                       i_es_load_sel,
  input  logic [`DS_GPR_ADDR_WD-1:0] i_ms_byp_rd,
  input  logic [`DS_XLEN-1:0]        i_ms_byp_data,
  input  logic [`DS_GPR_ADDR_WD-1:0] i_ws_byp_rd,
  input  logic [`DS_XLEN-1:0]        i_ws_byp_data,
  output logic                       o_ds_allowin,
  output logic                       o_ds_to_es_valid,
  output logic                       o_br_taken,
  output logic [`DS_XLEN-1:0]        o_br_target,
  // to es
  output logic [`DS_XLEN-1:0]        o_es_pc,
  output logic [`DS_XLEN-1:0]        o_es_rs1_data,
  output logic [`DS_XLEN-1:0]        o_es_rs2_data,
  output logic [`DS_XLEN-1:0]        o_es_imm,
  output logic [`DS_GPR_ADDR_WD-1:0] o_es_rd,
  output logic                       o_es_alu_op,
  output logic                       o_es_src2_imm_sel,
  output logic                       o_es_gpr_wen,
  output logic                       o_es_mem_ren,
  output logic                       o_es_mem_wen,
  output logic                       o_es_load_sel,
  output logic                       o_es_invalid
);

  rv_isa_pkg::rv_inst_u       ds_inst;
  ds_ctrl_pkg::ds_ctrl_t      ds_ctrl;
  logic [`DS_GPR_ADDR_WD-1:0] rs1;
  logic [`DS_GPR_ADDR_WD-1:0] rs2;
  logic                       load_hazard;

  gpr_read_if u_gpr_rd ();

  ds_stage_ctrl u_stage_ctrl (
    .i_clk            (i_clk),
    .i_rst            (i_rst),
    .i_fs_to_ds_valid (i_fs_to_ds_valid),
    .i_fs_inst        (i_fs_inst),
    .i_fs_pc          (i_fs_pc),
    .i_es_allowin     (i_es_allowin),
    .i_load_hazard    (load_hazard),
    .i_br_taken       (o_br_taken),
    .o_ds_allowin     (o_ds_allowin),
    .o_ds_to_es_valid (o_ds_to_es_valid),
    .o_inst           (ds_inst),
    .o_pc             (o_es_pc)
  );

  ds_decoder u_decoder (
    .i_inst (ds_inst),
    .o_rs1  (rs1),
    .o_rs2  (rs2),
    .o_rd   (o_es_rd),
    .o_imm  (o_es_imm),
    .o_ctrl (ds_ctrl)
  );

  ds_gpr_file u_gpr_file (
    .i_clk   (i_clk),
    .i_wen   (i_ws_gpr_wen),
    .i_waddr (i_ws_gpr_waddr),
    .i_wdata (i_ws_gpr_wdata),
    .rd_port (u_gpr_rd.regfile)
  );

  ds_operand_fwd u_operand_fwd (
    .i_rs1         (rs1),
    .i_rs2         (rs2),
    .i_es_byp_rd   (i_es_byp_rd),
    .i_es_byp_data (i_es_byp_data),
    .i_ms_byp_rd   (i_ms_byp_rd),
    .i_ms_byp_data (i_ms_byp_data),
    .i_ws_byp_rd   (i_ws_byp_rd),
    .i_ws_byp_data (i_ws_byp_data),
    .i_es_load_sel (i_es_load_sel),
    .rd_port       (u_gpr_rd.requester),
    .o_rs1_data    (o_es_rs1_data),
    .o_rs2_data    (o_es_rs2_data),
    .o_load_hazard (load_hazard)
  );

  ds_branch_unit u_branch_unit (
    .i_valid_out (o_ds_to_es_valid),
    .i_ctrl      (ds_ctrl),
    .i_pc        (o_es_pc),
    .i_imm       (o_es_imm),
    .i_rs1_data  (o_es_rs1_data),
    .i_rs2_data  (o_es_rs2_data),
    .i_fs_pc     (i_fs_pc),
    .o_br_taken  (o_br_taken),
    .o_br_target (o_br_target)
  );

  // control word onto plain ports
  assign o_es_alu_op       = ds_ctrl.alu_op;
  assign o_es_src2_imm_sel = ds_ctrl.src2_imm_sel;
  assign o_es_gpr_wen      = ds_ctrl.gpr_wen;
  assign o_es_mem_ren      = ds_ctrl.mem_ren;
  assign o_es_mem_wen      = ds_ctrl.mem_wen;
  assign o_es_load_sel     = ds_ctrl.load_sel;
  assign o_es_invalid      = ds_ctrl.invalid;

endmodule

// File: source/ds_branch_unit.sv
// beq/bne only; no redirect when fetch already holds the target pc
`include "ds_params.svh"

module ds_branch_unit (
  input  logic                  i_valid_out,
  input  ds_ctrl_pkg::ds_ctrl_t i_ctrl,
  input  logic [`DS_XLEN-1:0]   i_pc,
  input  logic [`DS_XLEN-1:0]   i_imm,
  input  logic [`DS_XLEN-1:0]   i_rs1_data,
  input  logic [`DS_XLEN-1:0]   i_rs2_data,
  input  logic [`DS_XLEN-1:0]   i_fs_pc,
  output logic                  o_br_taken,
  output logic [`DS_XLEN-1:0]   o_br_target
);

  logic ops_eq;
  logic br_cond;

  assign ops_eq      = (i_rs1_data == i_rs2_data);
  assign o_br_target = i_pc + i_imm; // imm already has bit 0 clear

  always_comb begin
    case (i_ctrl.br_kind)
      ds_ctrl_pkg::BR_EQ: br_cond = ops_eq;
      ds_ctrl_pkg::BR_NE: br_cond = ~ops_eq;
      default:            br_cond = 1'b0;
    endcase
  end

  assign o_br_taken = i_valid_out && br_cond && (o_br_target != i_fs_pc);

endmodule

// File: source/ds_operand_fwd.sv
// bypass rd of 0 means no offer; es load data is never forwarded, it stalls instead
`include "ds_params.svh"

module ds_operand_fwd (
  input  logic [`DS_GPR_ADDR_WD-1:0] i_rs1,
  input  logic [`DS_GPR_ADDR_WD-1:0] i_rs2,
  input  logic [`DS_GPR_ADDR_WD-1:0] i_es_byp_rd,
  input  logic [`DS_XLEN-1:0]        i_es_byp_data,
  input  logic [`DS_GPR_ADDR_WD-1:0] i_ms_byp_rd,
  input  logic [`DS_XLEN-1:0]        i_ms_byp_data,
  input  logic [`DS_GPR_ADDR_WD-1:0] i_ws_byp_rd,
  input  logic [`DS_XLEN-1:0]        i_ws_byp_data,
  input  logic                       i_es_load_sel,
  gpr_read_if.requester              rd_port,
  output logic [`DS_XLEN-1:0]        o_rs1_data,
  output logic [`DS_XLEN-1:0]        o_rs2_data,
  output logic                       o_load_hazard
);

  // youngest producer wins
  function automatic logic [`DS_XLEN-1:0] fwd_pick(input logic [`DS_GPR_ADDR_WD-1:0] rs,
                                                   input logic [`DS_XLEN-1:0] rf_data);
    if (i_es_byp_rd != '0 && rs == i_es_byp_rd) return i_es_byp_data;
    if (i_ms_byp_rd != '0 && rs == i_ms_byp_rd) return i_ms_byp_data;
    if (i_ws_byp_rd != '0 && rs == i_ws_byp_rd) return i_ws_byp_data;
    return rf_data;
  endfunction

  assign rd_port.rs1 = i_rs1;
  assign rd_port.rs2 = i_rs2;

  assign o_rs1_data = fwd_pick(i_rs1, rd_port.rs1_data);
  assign o_rs2_data = fwd_pick(i_rs2, rd_port.rs2_data);

  assign o_load_hazard = i_es_load_sel && (i_es_byp_rd != '0) &&
                         ((i_es_byp_rd == i_rs1) || (i_es_byp_rd == i_rs2));

endmodule

// File: source/ds_gpr_file.sv
// contents are undefined until written through write-back; x0 always reads zero
`include "ds_params.svh"

module ds_gpr_file (
  input  logic                       i_clk,
  input  logic                       i_wen,
  input  logic [`DS_GPR_ADDR_WD-1:0] i_waddr,
  input  logic [`DS_XLEN-1:0]        i_wdata,
  gpr_read_if.regfile                rd_port
);

  logic [`DS_XLEN-1:0] regs [`DS_GPR_NUM];

  always_ff @(posedge i_clk) begin
    if (i_wen && i_waddr != '0) begin
      regs[i_waddr] <= i_wdata;
    end
  end

  // no write-through; new value visible next cycle
  assign rd_port.rs1_data = (rd_port.rs1 == '0) ? '0 : regs[rd_port.rs1];
  assign rd_port.rs2_data = (rd_port.rs2 == '0) ? '0 : regs[rd_port.rs2];

endmodule

// File: source/ds_decoder.sv
// rv64i subset only; anything else is flagged invalid with all enables and register numbers cleared
`include "ds_params.svh"

module ds_decoder (
  input  rv_isa_pkg::rv_inst_u        i_inst,
  output logic [`DS_GPR_ADDR_WD-1:0]  o_rs1,
  output logic [`DS_GPR_ADDR_WD-1:0]  o_rs2,
  output logic [`DS_GPR_ADDR_WD-1:0]  o_rd,
  output logic [`DS_XLEN-1:0]         o_imm,
  output ds_ctrl_pkg::ds_ctrl_t       o_ctrl
);

  logic [2:0]          funct3;
  logic [6:0]          funct7;
  logic [`DS_XLEN-1:0] imm_i;
  logic [`DS_XLEN-1:0] imm_s;
  logic [`DS_XLEN-1:0] imm_b;

  assign funct3 = i_inst.r.funct3; // same position in every format
  assign funct7 = i_inst.r.funct7;

  assign imm_i = {{(`DS_XLEN-12){i_inst.i.imm[11]}}, i_inst.i.imm};
  assign imm_s = {{(`DS_XLEN-12){i_inst.s.imm_11_5[6]}}, i_inst.s.imm_11_5, i_inst.s.imm_4_0};
  assign imm_b = {{(`DS_XLEN-13){i_inst.b.imm_12}}, i_inst.b.imm_12, i_inst.b.imm_11,
                  i_inst.b.imm_10_5, i_inst.b.imm_4_1, 1'b0};

  always_comb begin
    o_rs1          = '0;
    o_rs2          = '0; // stays 0 when the format has no rs2
    o_rd           = '0;
    o_imm          = '0;
    o_ctrl         = '0;
    o_ctrl.invalid = 1'b1;
    case (i_inst.r.opcode)
      rv_isa_pkg::OP_IMM: begin
        if (funct3 == 3'b000) begin // addi
          o_rs1               = i_inst.i.rs1;
          o_rd                = i_inst.i.rd;
          o_imm               = imm_i;
          o_ctrl.src2_imm_sel = 1'b1;
          o_ctrl.gpr_wen      = 1'b1;
          o_ctrl.invalid      = 1'b0;
        end
      end
      rv_isa_pkg::OP: begin
        if (funct3 == 3'b000 && (funct7 == 7'b0000000 || funct7 == 7'b0100000)) begin
          o_rs1          = i_inst.r.rs1;
          o_rs2          = i_inst.r.rs2;
          o_rd           = i_inst.r.rd;
          o_ctrl.alu_op  = funct7[5] ? ds_ctrl_pkg::ALU_SUB : ds_ctrl_pkg::ALU_ADD;
          o_ctrl.gpr_wen = 1'b1;
          o_ctrl.invalid = 1'b0;
        end
      end
      rv_isa_pkg::LOAD: begin
        if (funct3 == 3'b011) begin // ld
          o_rs1               = i_inst.i.rs1;
          o_rd                = i_inst.i.rd;
          o_imm               = imm_i;
          o_ctrl.src2_imm_sel = 1'b1;
          o_ctrl.gpr_wen      = 1'b1;
          o_ctrl.mem_ren      = 1'b1;
          o_ctrl.load_sel     = 1'b1;
          o_ctrl.invalid      = 1'b0;
        end
      end
      rv_isa_pkg::STORE: begin
        if (funct3 == 3'b011) begin // sd
          o_rs1               = i_inst.s.rs1;
          o_rs2               = i_inst.s.rs2;
          o_imm               = imm_s;
          o_ctrl.src2_imm_sel = 1'b1; // address = rs1 + imm
          o_ctrl.mem_wen      = 1'b1;
          o_ctrl.invalid      = 1'b0;
        end
      end
      rv_isa_pkg::BRANCH: begin
        if (funct3 == 3'b000 || funct3 == 3'b001) begin
          o_rs1          = i_inst.b.rs1;
          o_rs2          = i_inst.b.rs2;
          o_imm          = imm_b;
          o_ctrl.br_kind = funct3[0] ? ds_ctrl_pkg::BR_NE : ds_ctrl_pkg::BR_EQ;
          o_ctrl.invalid = 1'b0;
        end
      end
      default: ;
    endcase
  end

endmodule

// File: source/ds_stage_ctrl.sv
// single-entry stage; a taken branch replaces whatever fetch presents that cycle with a nop
`include "ds_params.svh"

module ds_stage_ctrl (
  input  logic                 i_clk,
  input  logic                 i_rst,
  input  logic                 i_fs_to_ds_valid,
  input  logic [`DS_INST_WD-1:0] i_fs_inst,
  input  logic [`DS_XLEN-1:0]  i_fs_pc,
  input  logic                 i_es_allowin,
  input  logic                 i_load_hazard,
  input  logic                 i_br_taken,
  output logic                 o_ds_allowin,
  output logic                 o_ds_to_es_valid,
  output rv_isa_pkg::rv_inst_u o_inst,
  output logic [`DS_XLEN-1:0]  o_pc
);

  logic ds_valid;
  logic ds_ready_go;

  assign ds_ready_go      = ~i_load_hazard; // wait for load to reach mem
  assign o_ds_allowin     = ~ds_valid | (ds_ready_go & i_es_allowin);
  assign o_ds_to_es_valid = ds_valid & ds_ready_go;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      ds_valid <= 1'b0;
    end else if (o_ds_allowin) begin
      ds_valid <= i_fs_to_ds_valid;
    end
  end

  // inst and pc move together
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_inst <= `DS_NOP_INST; // idle as nop
      o_pc   <= '0;
    end else if (i_fs_to_ds_valid && o_ds_allowin) begin
      o_inst <= i_br_taken ? `DS_NOP_INST : i_fs_inst; // squash wrong-path fetch
      o_pc   <= i_fs_pc;
    end
  end

endmodule

// File: source/gpr_read_if.sv
// combinational read path, no handshake; data is valid in the same cycle as the addresses
`include "ds_params.svh"

interface gpr_read_if;

  logic [`DS_GPR_ADDR_WD-1:0] rs1;
  logic [`DS_GPR_ADDR_WD-1:0] rs2;
  logic [`DS_XLEN-1:0]        rs1_data;
  logic [`DS_XLEN-1:0]        rs2_data;

  modport requester (output rs1, output rs2, input rs1_data, input rs2_data);

  modport regfile (input rs1, input rs2, output rs1_data, output rs2_data);

endinterface

// File: source/ds_ctrl_pkg.sv
// control word covers addi/add/sub/ld/sd/beq/bne only; loads and stores are doubleword
package ds_ctrl_pkg;

  typedef enum logic {
    ALU_ADD = 1'b0,
    ALU_SUB = 1'b1
  } ds_alu_op_e;

  typedef enum logic [1:0] {
    BR_NONE = 2'd0,
    BR_EQ   = 2'd1,
    BR_NE   = 2'd2
  } ds_br_kind_e;

  typedef struct packed {
    ds_alu_op_e  alu_op;
    logic        src2_imm_sel; // alu src2 from imm
    logic        gpr_wen;
    logic        mem_ren;
    logic        mem_wen;
    logic        load_sel;     // result comes back late, from mem
    ds_br_kind_e br_kind;
    logic        invalid;
  } ds_ctrl_t;

endpackage

// File: source/rv_isa_pkg.sv
// only the major opcodes used by the decode subset are listed; compressed forms are not covered
`include "ds_params.svh"

package rv_isa_pkg;

  typedef enum logic [6:0] {
    OP_IMM = 7'b0010011,
    OP     = 7'b0110011,
    LOAD   = 7'b0000011,
    STORE  = 7'b0100011,
    BRANCH = 7'b1100011
  } rv_opcode_e;

  typedef struct packed {
    logic [6:0]                 funct7;
    logic [`DS_GPR_ADDR_WD-1:0] rs2;
    logic [`DS_GPR_ADDR_WD-1:0] rs1;
    logic [2:0]                 funct3;
    logic [`DS_GPR_ADDR_WD-1:0] rd;
    logic [6:0]                 opcode;
  } rv_r_fmt_t;

  typedef struct packed {
    logic [11:0]                imm;
    logic [`DS_GPR_ADDR_WD-1:0] rs1;
    logic [2:0]                 funct3;
    logic [`DS_GPR_ADDR_WD-1:0] rd;
    logic [6:0]                 opcode;
  } rv_i_fmt_t;

  typedef struct packed {
    logic [6:0]                 imm_11_5;
    logic [`DS_GPR_ADDR_WD-1:0] rs2;
    logic [`DS_GPR_ADDR_WD-1:0] rs1;
    logic [2:0]                 funct3;
    logic [4:0]                 imm_4_0;
    logic [6:0]                 opcode;
  } rv_s_fmt_t;

  // b immediate is scattered, bit 0 implied zero
  typedef struct packed {
    logic                       imm_12;
    logic [5:0]                 imm_10_5;
    logic [`DS_GPR_ADDR_WD-1:0] rs2;
    logic [`DS_GPR_ADDR_WD-1:0] rs1;
    logic [2:0]                 funct3;
    logic [3:0]                 imm_4_1;
    logic                       imm_11;
    logic [6:0]                 opcode;
  } rv_b_fmt_t;

  typedef union packed {
    rv_r_fmt_t r;
    rv_i_fmt_t i;
    rv_s_fmt_t s;
    rv_b_fmt_t b;
  } rv_inst_u;

endpackage

// File: source/ds_params.svh
// widths fixed for rv64; changing DS_XLEN alone does not make an rv32 stage
`ifndef DS_PARAMS_SVH
`define DS_PARAMS_SVH

// data path and pc
`define DS_XLEN         64
`define DS_INST_WD      32

// general registers
`define DS_GPR_ADDR_WD  5
`define DS_GPR_NUM      32

// addi x0, x0, 0
`define DS_NOP_INST     32'h0000_0013

`endif
